//--- files.f
+incdir+hdl
+incdir+dv
hdl/countPkg.sv
hdl/bitSynchronizer.sv
hdl/dualClockFifo.sv
hdl/componentCounter.sv
hdl/slotMemory.sv
hdl/streamingCountCore.sv
dv/streamingCountCoreTb.sv

//--- dv/componentModel.svh
`ifndef COMPONENT_MODEL_SVH
`define COMPONENT_MODEL_SVH

// Graph helpers, included inside the testbench module
// Edge bits walk the upper triangle row by row, edge (0,1) first

function automatic int edgeIndex(input int a, input int b);
    int idx;
    int found;
    idx = 0;
    found = -1;
    for (int i = 0; i < `NODE_COUNT; i++) begin
        for (int j = i + 1; j < `NODE_COUNT; j++) begin
            if ((i == a && j == b) || (i == b && j == a)) begin
                found = idx;
            end
            idx++;
        end
    end
    return found;
endfunction

function automatic countPkg::graphT withEdge(input countPkg::graphT graph, input int a,
                                             input int b);
    countPkg::graphT result;
    result = graph;
    result[edgeIndex(a, b)] = 1'b1;
    return result;
endfunction

// Eight disjoint edges (0,1) (2,3) .. (14,15)
function automatic countPkg::graphT pairsGraph();
    countPkg::graphT graph;
    graph = '0;
    for (int k = 0; k < `NODE_COUNT / 2; k++) begin
        graph = withEdge(graph, 2 * k, 2 * k + 1);
    end
    return graph;
endfunction

// One path through all nodes in order
function automatic countPkg::graphT pathGraph();
    countPkg::graphT graph;
    graph = '0;
    for (int n = 0; n < `NODE_COUNT - 1; n++) begin
        graph = withEdge(graph, n, n + 1);
    end
    return graph;
endfunction

// Triangles on 5..7 and 12..14, the other ten nodes isolated
function automatic countPkg::graphT twoTrianglesGraph();
    countPkg::graphT graph;
    graph = '0;
    graph = withEdge(graph, 5, 6);
    graph = withEdge(graph, 6, 7);
    graph = withEdge(graph, 5, 7);
    graph = withEdge(graph, 12, 13);
    graph = withEdge(graph, 13, 14);
    graph = withEdge(graph, 12, 14);
    return graph;
endfunction

// Min-label propagation until every edge joins equal labels
function automatic countPkg::countT countComponents(input countPkg::graphT graph);
    int label [`NODE_COUNT];
    int idx;
    int total;
    logic changed;
    for (int n = 0; n < `NODE_COUNT; n++) begin
        label[n] = n;
    end
    changed = 1'b1;
    while (changed) begin
        changed = 1'b0;
        idx = 0;
        for (int a = 0; a < `NODE_COUNT; a++) begin
            for (int b = a + 1; b < `NODE_COUNT; b++) begin
                if (graph[idx] && label[a] != label[b]) begin
                    if (label[a] < label[b]) begin
                        label[b] = label[a];
                    end else begin
                        label[a] = label[b];
                    end
                    changed = 1'b1;
                end
                idx++;
            end
        end
    end
    // Each component keeps the label of its lowest node
    total = 0;
    for (int n = 0; n < `NODE_COUNT; n++) begin
        if (label[n] == n) begin
            total++;
        end
    end
    return countPkg::countT'(total);
endfunction

`endif

//--- dv/streamingCountCoreTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "countCore_cfg.svh"

module streamingCountCoreTb;

    // From the input's falling edge to its checked output, no freeze
    localparam int LAP = 514;
    localparam int SETTLE = 8;
    localparam int LATENCY_CYCLES = 60;
    localparam int STREAM_CYCLES = 300;
    localparam int FREEZE_INPUTS = 20;
    localparam int FREEZE_EARLY = 3;
    localparam int FREEZE_LATE = 12;

    // Stimulus of each test plus its drain lap, then two spare laps
    localparam int CYCLE_LIMIT = 10 + (LAP + SETTLE) + (5 + LAP + SETTLE)
        + (LATENCY_CYCLES + LAP + SETTLE) + (STREAM_CYCLES + LAP + SETTLE)
        + (2 * FREEZE_INPUTS + FREEZE_EARLY + FREEZE_LATE + 2 * LAP + SETTLE) + 2 * LAP;

    typedef struct packed {
        countPkg::countT count;
        countPkg::tagT tag;
        int due;
    } expectT;

    logic clk;
    logic clk2x;
    logic rst;
    logic isValid;
    countPkg::graphT graphIn;
    countPkg::tagT tagIn;
    logic freeze;
    logic almostFull;
    logic resultValid;
    countPkg::countT connectCount;
    countPkg::tagT tagOut;

    expectT scoreboard [$];
    int cycle = 0;
    logic [1:0] freezeSeen = '0;
    logic checking = 1'b0;
    logic sawAlmostFull = 1'b0;
    integer seed = 32'h32847589;
    int errorCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int testStartErrors = 0;
    string testName;

    `include "componentModel.svh"

    streamingCountCore dut_i (
        .clk(clk),
        .clk2x(clk2x),
        .rst(rst),
        .isValid(isValid),
        .graphIn(graphIn),
        .tagIn(tagIn),
        .freeze(freeze),
        .almostFull(almostFull),
        .resultValid(resultValid),
        .connectCount(connectCount),
        .tagOut(tagOut)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Starts high so its rising edges line up with clk
    initial begin
        clk2x = 1'b1;
        forever #1 clk2x = ~clk2x;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        freezeSeen <= {freezeSeen[0], freeze};
    end

    always @(posedge clk) begin
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    task automatic logMismatch(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        errorCount++;
        $display("mismatch %s at cycle %0d: got 0x%0h, expected 0x%0h", name, cycle, got, want);
    endtask

    task automatic raiseError(input string what);
        errorCount++;
        $display("error at cycle %0d: %s", cycle, what);
    endtask

    // Outputs are stable on the falling edge
    always @(negedge clk) begin : checkOutputs
        expectT due;
        if (checking) begin
            if (scoreboard.size() > 0 && scoreboard[0].due == cycle) begin
                due = scoreboard.pop_front();
                assert (resultValid === 1'b1)
                    else logMismatch("resultValid", 32'(resultValid), 32'h1);
                assert (connectCount === due.count)
                    else logMismatch("connectCount", 32'(connectCount), 32'(due.count));
                assert (tagOut === due.tag)
                    else logMismatch("tagOut", 32'(tagOut), 32'(due.tag));
            end else begin
                assert (resultValid === 1'b0)
                    else logMismatch("resultValid", 32'(resultValid), 32'h0);
            end
            // Read at a frozen edge gives zero one cycle later
            if (freezeSeen[1]) begin
                assert (resultValid === 1'b0)
                    else raiseError("resultValid high after a frozen read");
            end
        end
    end

    task automatic openTest(input string name);
        testName = name;
        testStartErrors = errorCount;
    endtask

    task automatic closeTest();
        int errors;
        errors = errorCount - testStartErrors;
        testsRun++;
        if (errors == 0) begin
            $display("test %s: passed", testName);
        end else begin
            testsFailed++;
            $display("test %s: failed with %0d errors", testName, errors);
        end
    endtask

    task automatic driveCycle(input logic wantValid, input countPkg::graphT graph,
                              input countPkg::tagT tag, input logic frozen,
                              input countPkg::countT expected);
        expectT entry;
        logic valid;
        @(negedge clk);
        // Source holds off while the FIFO is nearly full
        valid = wantValid && !almostFull;
        if (wantValid && almostFull) begin
            sawAlmostFull = 1'b1;
        end
        isValid = valid;
        graphIn = graph;
        tagIn = tag;
        freeze = frozen;
        if (frozen) begin
            // A frozen edge delays every readout still ahead of it
            foreach (scoreboard[i]) begin
                if (scoreboard[i].due >= cycle + 2) begin
                    scoreboard[i].due = scoreboard[i].due + 1;
                end
            end
        end else if (valid) begin
            entry.count = expected;
            entry.tag = tag;
            entry.due = cycle + LAP;
            scoreboard.push_back(entry);
        end
    endtask

    task automatic idleCycle();
        driveCycle(1'b0, '0, '0, 1'b0, '0);
    endtask

    task automatic waitDrained();
        while (scoreboard.size() != 0) begin
            idleCycle();
        end
        repeat (SETTLE) begin
            idleCycle();
        end
    endtask

    // More thinning gives sparser graphs with more components
    function automatic countPkg::graphT randomGraph(input int thinning);
        countPkg::graphT graph;
        graph = '1;
        repeat (thinning) begin
            graph = graph & {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        return graph;
    endfunction

    initial begin
        countPkg::graphT graph;
        countPkg::graphT fixedGraphs [5];
        countPkg::countT fixedCounts [5];
        countPkg::tagT tag;
        logic want;
        logic frozen;
        int freezeEnd;

        rst = 1'b1;
        isValid = 1'b0;
        graphIn = '0;
        tagIn = '0;
        freeze = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (4) @(posedge clk);
        checking = 1'b1;

        openTest("reset_idle");
        idleCycle();
        assert (almostFull === 1'b0)
            else logMismatch("almostFull", 32'(almostFull), 32'h0);
        repeat (LAP) begin
            idleCycle();
        end
        closeTest();

        openTest("fixed_graphs");
        fixedGraphs[0] = '0;
        fixedCounts[0] = countPkg::countT'(16);
        fixedGraphs[1] = '1;
        fixedCounts[1] = countPkg::countT'(1);
        fixedGraphs[2] = pairsGraph();
        fixedCounts[2] = countPkg::countT'(8);
        fixedGraphs[3] = pathGraph();
        fixedCounts[3] = countPkg::countT'(1);
        fixedGraphs[4] = twoTrianglesGraph();
        fixedCounts[4] = countPkg::countT'(12);
        for (int n = 0; n < 5; n++) begin
            assert (countComponents(fixedGraphs[n]) == fixedCounts[n])
                else raiseError("reference model disagrees with a fixed graph count");
            driveCycle(1'b1, fixedGraphs[n], countPkg::tagT'(n + 1), 1'b0, fixedCounts[n]);
        end
        waitDrained();
        closeTest();

        openTest("latency");
        for (int n = 0; n < LATENCY_CYCLES; n++) begin
            graph = randomGraph(2);
            want = 1'($random(seed));
            tag = countPkg::tagT'($random(seed));
            driveCycle(want, graph, tag, 1'b0, countComponents(graph));
        end
        waitDrained();
        closeTest();

        openTest("random_stream");
        sawAlmostFull = 1'b0;
        for (int n = 0; n < STREAM_CYCLES; n++) begin
            graph = randomGraph(1 + n % 4);
            tag = countPkg::tagT'($random(seed));
            driveCycle(1'b1, graph, tag, 1'b0, countComponents(graph));
        end
        waitDrained();
        assert (sawAlmostFull)
            else raiseError("almostFull never rose during the full-rate stream");
        closeTest();

        openTest("freeze");
        // Short freeze in the middle of the input burst, strobes ignored
        for (int n = 0; n < 2 * FREEZE_INPUTS + FREEZE_EARLY; n++) begin
            graph = randomGraph(1 + n % 3);
            tag = countPkg::tagT'($random(seed));
            frozen = (n >= FREEZE_INPUTS) && (n < FREEZE_INPUTS + FREEZE_EARLY);
            driveCycle(1'b1, graph, tag, frozen, countComponents(graph));
        end
        // Longer freeze across the first readouts
        while (scoreboard[0].due > cycle + 4) begin
            idleCycle();
        end
        for (int n = 0; n < FREEZE_LATE; n++) begin
            graph = randomGraph(1);
            tag = countPkg::tagT'($random(seed));
            driveCycle(1'b1, graph, tag, 1'b1, countComponents(graph));
        end
        freezeEnd = cycle;
        waitDrained();
        // Frozen strobes would surface about a lap after the freeze
        while (cycle < freezeEnd + LAP + SETTLE) begin
            idleCycle();
        end
        closeTest();

        $display("summary: %0d tests run, %0d failed, %0d errors",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/streamingCountCore.sv
`timescale 1ns/10ps
`default_nettype none

module streamingCountCore (
    input logic clk,
    input logic clk2x,
    input logic rst,

    // Input side
    input logic isValid,
    input countPkg::graphT graphIn,
    input countPkg::tagT tagIn,
    input logic freeze,
    output logic almostFull,

    // Output side
    output logic resultValid,
    output countPkg::countT connectCount,
    output countPkg::tagT tagOut
);

    logic rstQ;
    logic rstSync2x;
    logic fifoRst2x;
    logic coreRst2x;

    countPkg::slotT slot;
    countPkg::slotT slotD;
    countPkg::slotRecordT recordQ;
    countPkg::slotRecordT recordRd;
    countPkg::countT countRd;

    logic push;
    countPkg::workItemT workIn;
    countPkg::workItemT work2x;
    logic itemAvailable2x;
    logic pop2x;
    logic resultWrite2x;
    countPkg::resultT result2x;

    // Reset fan-out
    always_ff @(posedge clk) begin
        rstQ <= rst;
    end

    bitSynchronizer #(
        .WIDTH(1)
    ) rstSync (
        .clk(clk2x),
        .d(rstQ),
        .q(rstSync2x)
    );

    always_ff @(posedge clk2x) begin
        fifoRst2x <= rstSync2x;
        coreRst2x <= rstSync2x;
    end

    // Slot ring, stopped by freeze
    always_ff @(posedge clk) begin
        if (rstQ) begin
            slot <= '0;
        end else if (!freeze) begin
            slot <= slot + 1'b1;
        end
    end

    // Record of this cycle lands one slot behind the read pointer
    // Reset to the last slot so the first write misses slot 0
    always_ff @(posedge clk) begin
        if (rstQ) begin
            slotD <= '1;
            recordQ <= '0;
        end else if (!freeze) begin
            slotD <= slot;
            recordQ <= '{valid: isValid, tag: tagIn};
        end
    end

    assign push = isValid && !freeze;
    assign workIn = '{graph: graphIn, slot: slot};

    dualClockFifo #(
        .payloadT(countPkg::workItemT)
    ) inputFifo (
        .wrClk(clk),
        .wrRst(rstQ),
        .push(push),
        .wrData(workIn),
        .almostFull(almostFull),
        .rdClk(clk2x),
        .rdRst(fifoRst2x),
        .pop(pop2x),
        .rdData(work2x),
        .notEmpty(itemAvailable2x)
    );

    componentCounter counter (
        .clk(clk2x),
        .rst(coreRst2x),
        .item(work2x),
        .itemAvailable(itemAvailable2x),
        .pop(pop2x),
        .resultWrite(resultWrite2x),
        .result(result2x)
    );

    slotMemory #(
        .payloadT(countPkg::countT)
    ) resultMemory (
        .wrClk(clk2x),
        .write(resultWrite2x),
        .wrAddr(result2x.slot),
        .wrData(result2x.count),
        .rdClk(clk),
        .readEnable(!freeze),
        .rdAddr(slot),
        .rdData(countRd)
    );

    slotMemory #(
        .payloadT(countPkg::slotRecordT)
    ) validMemory (
        .wrClk(clk),
        .write(!freeze),
        .wrAddr(slotD),
        .wrData(recordQ),
        .rdClk(clk),
        .readEnable(!freeze),
        .rdAddr(slot),
        .rdData(recordRd)
    );

    // Output stage, second cycle after the slot read
    always_ff @(posedge clk) begin
        if (rstQ) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= recordRd.valid;
        end
    end

    always_ff @(posedge clk) begin
        connectCount <= countRd;
        tagOut <= recordRd.tag;
    end

endmodule

`default_nettype wire

//--- hdl/slotMemory.sv
`timescale 1ns/10ps
`default_nettype none

module slotMemory #(
    parameter type payloadT = logic
) (
    // Write port
    input logic wrClk,
    input logic write,
    input countPkg::slotT wrAddr,
    input payloadT wrData,

    // Read port
    input logic rdClk,
    input logic readEnable,
    input countPkg::slotT rdAddr,
    output payloadT rdData
);

    localparam int DEPTH = 2 ** $bits(countPkg::slotT);

    payloadT mem [DEPTH];

    // Power-up contents are zero
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge wrClk) begin
        if (write) begin
            mem[wrAddr] <= wrData;
        end
    end

    // Disabled reads give zero instead of holding
    always_ff @(posedge rdClk) begin
        rdData <= readEnable ? mem[rdAddr] : '0;
    end

endmodule

`default_nettype wire

//--- hdl/componentCounter.sv
`timescale 1ns/10ps
`default_nettype none

`include "countCore_cfg.svh"

module componentCounter (
    input logic clk,
    input logic rst,
    input countPkg::workItemT item,
    input logic itemAvailable,
    output logic pop,
    output logic resultWrite,
    output countPkg::resultT result
);

    localparam int NODES = `NODE_COUNT;

    typedef enum logic [2:0] {
        IDLE,
        SINGLETON,
        SEED,
        GROW,
        WRITE
    } stateT;

    typedef logic [NODES-1:0] nodeMaskT;

    stateT state;

    logic [`EDGE_BITS-1:0] edgeBits;
    nodeMaskT unpacked [NODES];
    nodeMaskT adjacency [NODES];

    nodeMaskT isolatedMask;
    nodeMaskT unvisited;
    nodeMaskT lowestUnvisited;
    nodeMaskT reached;
    nodeMaskT grown;

    countPkg::slotT slot;
    countPkg::countT count;
    countPkg::countT isolatedCount;

    assign edgeBits = item.graph[`EDGE_BITS-1:0];

    // Row-major triangle into symmetric rows
    always_comb begin
        for (int i = 0; i < NODES; i++) begin
            unpacked[i] = '0;
        end
        for (int i = 0; i < NODES; i++) begin
            for (int j = i + 1; j < NODES; j++) begin
                unpacked[i][j] = edgeBits[i * (2 * NODES - i - 1) / 2 + j - i - 1];
                unpacked[j][i] = edgeBits[i * (2 * NODES - i - 1) / 2 + j - i - 1];
            end
        end
    end

    always_comb begin
        for (int n = 0; n < NODES; n++) begin
            isolatedMask[n] = adjacency[n] == '0;
        end
    end

    assign isolatedCount = countPkg::countT'($countones(isolatedMask));

    // Lowest set bit
    assign lowestUnvisited = unvisited & (~unvisited + 1'b1);

    // One hop out from everything reached so far
    always_comb begin
        grown = reached;
        for (int n = 0; n < NODES; n++) begin
            if (reached[n]) begin
                grown = grown | adjacency[n];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (itemAvailable) begin
                        state <= SINGLETON;
                    end
                end
                SINGLETON: state <= (isolatedMask == '1) ? WRITE : SEED;
                SEED: state <= GROW;
                GROW: begin
                    // Settled, so this component is done
                    if (grown == reached) begin
                        state <= ((unvisited & ~reached) == '0) ? WRITE : SEED;
                    end
                end
                WRITE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (itemAvailable) begin
                    adjacency <= unpacked;
                    slot <= item.slot;
                end
            end
            SINGLETON: begin
                // All isolated nodes counted at once
                count <= isolatedCount;
                unvisited <= ~isolatedMask;
            end
            SEED: reached <= lowestUnvisited;
            GROW: begin
                reached <= grown;
                if (grown == reached) begin
                    count <= count + 1'b1;
                    unvisited <= unvisited & ~reached;
                end
            end
            default: ;
        endcase
    end

    assign pop = (state == IDLE) && itemAvailable;
    assign resultWrite = state == WRITE;
    assign result = '{slot: slot, count: count};

endmodule

`default_nettype wire

//--- hdl/dualClockFifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "countCore_cfg.svh"

module dualClockFifo #(
    parameter type payloadT = logic
) (
    // Write side
    input logic wrClk,
    input logic wrRst,
    input logic push,
    input payloadT wrData,
    output logic almostFull,

    // Read side
    input logic rdClk,
    input logic rdRst,
    input logic pop,
    output payloadT rdData,
    output logic notEmpty
);

    localparam int DEPTH = 2 ** `FIFO_DEPTH_BITS;
    localparam int PTR_BITS = `FIFO_DEPTH_BITS + 1;

    typedef logic [PTR_BITS-1:0] ptrT;

    payloadT store [DEPTH];

    // Pointers start known so the flags are clean while resets ripple across
    ptrT wrBin = '0;
    ptrT wrGray = '0;
    ptrT rdBin = '0;
    ptrT rdGray = '0;

    ptrT wrBinNext;
    ptrT rdBinNext;
    ptrT rdGraySync;
    ptrT wrGraySync;
    ptrT rdBinSync;
    ptrT level;

    function automatic ptrT grayToBin(input ptrT gray);
        ptrT bin;
        bin[PTR_BITS-1] = gray[PTR_BITS-1];
        for (int i = PTR_BITS - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    bitSynchronizer #(
        .WIDTH(PTR_BITS)
    ) rdPtrSync (
        .clk(wrClk),
        .d(rdGray),
        .q(rdGraySync)
    );

    bitSynchronizer #(
        .WIDTH(PTR_BITS)
    ) wrPtrSync (
        .clk(rdClk),
        .d(wrGray),
        .q(wrGraySync)
    );

    // Write domain
    assign wrBinNext = wrBin + ptrT'(push);
    assign rdBinSync = grayToBin(rdGraySync);

    // Fill level after this cycle's push, seen against a stale read pointer
    assign level = wrBinNext - rdBinSync;

    always_ff @(posedge wrClk) begin
        if (wrRst) begin
            wrBin <= '0;
            wrGray <= '0;
            almostFull <= 1'b0;
        end else begin
            wrBin <= wrBinNext;
            wrGray <= wrBinNext ^ (wrBinNext >> 1);
            almostFull <= level >= ptrT'(DEPTH - `FIFO_MARGIN);
        end
    end

    always_ff @(posedge wrClk) begin
        if (push) begin
            store[wrBin[`FIFO_DEPTH_BITS-1:0]] <= wrData;
        end
    end

    // Read domain
    assign notEmpty = rdGray != wrGraySync;
    assign rdBinNext = rdBin + 1'b1;

    // Show-ahead head entry
    assign rdData = store[rdBin[`FIFO_DEPTH_BITS-1:0]];

    always_ff @(posedge rdClk) begin
        if (rdRst) begin
            rdBin <= '0;
            rdGray <= '0;
        end else if (pop && notEmpty) begin
            rdBin <= rdBinNext;
            rdGray <= rdBinNext ^ (rdBinNext >> 1);
        end
    end

endmodule

`default_nettype wire

//--- hdl/bitSynchronizer.sv
`timescale 1ns/10ps
`default_nettype none

module bitSynchronizer #(
    parameter int WIDTH = 1
) (
    input logic clk,
    input logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q
);

    // Power-up value keeps the far side defined before any reset arrives
    logic [WIDTH-1:0] meta = '0;
    logic [WIDTH-1:0] held = '0;

    // Two flops, first one may go metastable
    always_ff @(posedge clk) begin
        meta <= d;
        held <= meta;
    end

    assign q = held;

endmodule

`default_nettype wire

//--- hdl/countPkg.sv
`default_nettype none

`include "countCore_cfg.svh"

package countPkg;

    // Upper triangle of the adjacency matrix, row-major:
    // bit 0 is edge (0,1), then (0,2) .. (0,15), (1,2) .. (14,15)
    // Bits above EDGE_BITS are ignored
    typedef logic [`GRAPH_BITS-1:0] graphT;

    typedef logic [`SLOT_BITS-1:0] slotT;

    typedef logic [`COUNT_BITS-1:0] countT;

    typedef logic [`TAG_BITS-1:0] tagT;

    // FIFO payload toward the clk2x core
    typedef struct packed {
        graphT graph;
        slotT slot;
    } workItemT;

    // Per-slot record kept on the clk side
    typedef struct packed {
        logic valid;
        tagT tag;
    } slotRecordT;

    // Core output, written to the result memory at slot
    typedef struct packed {
        slotT slot;
        countT count;
    } resultT;

endpackage

`default_nettype wire

//--- hdl/countCore_cfg.svh
`ifndef COUNT_CORE_CFG_SVH
`define COUNT_CORE_CFG_SVH

// Ring of result slots, one per clk cycle of latency
`define SLOT_BITS 9

// Graph shape
`define NODE_COUNT 16
`define EDGE_BITS 120
`define GRAPH_BITS 128

// Holds counts up to NODE_COUNT
`define COUNT_BITS 5

// Caller tag carried alongside each graph
`define TAG_BITS 1

// Input FIFO, 16 entries
`define FIFO_DEPTH_BITS 4

// Free entries at or below which almostFull rises
`define FIFO_MARGIN 4

`endif
